// File: vlog.f
+incdir+design
design/prbs_pkg.sv
design/prbs_generator.sv
design/rx_bit_source.sv
design/capture_memory.sv
design/prbs_checker.sv
design/prbs_bist_top.sv
testbench/prbs_bist_assert.sv
testbench/tb_prbs_bist.sv

// File: Bender.yml
package:
  name: prbs_bist

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/prbs_pkg.sv
      - design/prbs_generator.sv
      - design/rx_bit_source.sv
      - design/capture_memory.sv
      - design/prbs_checker.sv
      - design/prbs_bist_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/prbs_bist_assert.sv
      - testbench/tb_prbs_bist.sv

// File: testbench/tb_prbs_bist.sv
`timescale 1ns/1ps
`default_nettype none

`include "prbs_defs.svh"

module tb_prbs_bist import prbs_pkg::*; ();

    // words aligned before each test window
    localparam int ALIGN_WORDS = 2;
    localparam int N_ROWS = 5;

    typedef struct {
        rx_src_e     src;
        logic [7:0]  thresh;
        logic [31:0] eqn;
        logic [31:0] seed;
        logic [15:0] mask;
        int          nwords;
        int          ninj;
        int          exp_err;
        int          exp_tot;
    } row_t;

    logic                           clk_adc = 1'b0;
    logic                           rst_i;
    logic [`NTI-1:0][`NADC-1:0]     codes_i;
    logic [`NADC-1:0]               thresh_i;
    rx_src_e                        src_i;
    logic                           gen_cke_i;
    logic [`NPRBS-1:0]              gen_seed_i;
    logic [`NPRBS-1:0]              gen_eqn_i;
    logic                           gen_inj_err_i;
    logic                           dump_start_i;
    logic [`CAP_AW-1:0]             rd_addr_i;
    logic [`NTI-1:0]                rd_word_o;
    logic                           cap_done_o;
    chk_mode_e                      mode_i;
    logic [`NPRBS-1:0]              chk_eqn_i;
    logic [`NTI-1:0]                lane_mask_i;
    rd_sel_e                        rd_sel_i;
    logic [`RD_W-1:0]               rd_data_o;

    row_t        rows [N_ROWS];
    logic [31:0] lcg_state = 32'd85200;
    logic [31:0] model_state;
    int          n_checks = 0;
    int          n_errors = 0;

    always #20 clk_adc = ~clk_adc;

    prbs_bist_top prbs_bist_top_i (.*);

    bind prbs_bist_top prbs_bist_assert bist_assert_i (
        .clk_i(clk_adc), .rst_i(rst_i), .valid_in_i(rx_valid), .valid_out_i(chk_valid),
        .start_i(dump_start_i), .done_i(cap_done_o), .mode_i(mode_i),
        .err_cnt_i(prbs_checker_i.err_cnt), .tot_cnt_i(prbs_checker_i.tot_cnt)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;
    endfunction

    // reference PRBS, newest bit at position 0
    function automatic logic model_next(input logic [31:0] eqn);
        logic b;
        b = ^(model_state & eqn);
        model_state = {model_state[30:0], b};
        return b;
    endfunction

    // random code on the requested side of the threshold
    function automatic logic [7:0] code_for(input logic b, input logic [7:0] th);
        int t;
        int r;
        t = int'($signed(th));
        r = int'(lcg_next() % 1024);
        if (b)
            return 8'(t + 1 + (r % (127 - t)));
        return 8'(t - (r % (t + 129)));
    endfunction

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] expv);
        n_checks++;
        assert (got == expv) else begin
            n_errors++;
            $display("** Error @ %0t: %s read %0d, expected %0d", $time, what, got, expv);
        end
    endtask

    task automatic read_half(input rd_sel_e sel, input logic [31:0] expv);
        @(posedge clk_adc);
        rd_sel_i <= sel;
        @(negedge clk_adc);
        check_value(sel.name(), rd_data_o, expv);
    endtask

    task automatic apply_reset();
        @(posedge clk_adc);
        rst_i  <= 1'b1;
        mode_i <= CHK_CLEAR;
        repeat (2) @(posedge clk_adc);
        rst_i <= 1'b0;
    endtask

    task automatic capture_window();
        logic [`NTI-1:0]            exp_word [`CAP_DEPTH];
        logic [`NTI-1:0][`NADC-1:0] cv;
        logic [7:0]                 th;
        logic                       bit_v;
        int                         wait_cnt;
        // threshold below 127 so both sides of it hold codes
        th = 8'(int'(lcg_next() % 255) - 128);
        @(posedge clk_adc);
        src_i    <= SRC_ADC;
        thresh_i <= th;
        apply_reset();
        for (int k = 0; k < `CAP_DEPTH; k++) begin
            @(posedge clk_adc);
            for (int i = 0; i < `NTI; i++) begin
                bit_v = (lcg_next() % 2) != 0;
                cv[i] = code_for(bit_v, th);
                exp_word[k][i] = bit_v;
            end
            codes_i      <= cv;
            dump_start_i <= (k == 0);
        end
        // last word not stored yet
        check_value("cap_done before window end", 32'(cap_done_o), 32'd0);
        wait_cnt = 0;
        while (!cap_done_o && wait_cnt < 10) begin
            @(posedge clk_adc);
            wait_cnt++;
        end
        if (!cap_done_o) begin
            n_errors++;
            $display("capture window never completed, cap_done stayed low");
        end
        for (int a = 0; a < `CAP_DEPTH; a++) begin
            @(posedge clk_adc);
            rd_addr_i <= `CAP_AW'(a);
            @(posedge clk_adc);
            @(negedge clk_adc);
            check_value($sformatf("capture word %0d", a), 32'(rd_word_o), 32'(exp_word[a]));
        end
    endtask

    task automatic run_row(input row_t row);
        logic                       flip_at [256];
        logic [`NTI-1:0][`NADC-1:0] cv;
        logic                       b;
        int                         last;
        for (int t = 0; t < 256; t++)
            flip_at[t] = 1'b0;
        // errors land in the test window, at least two words apart
        for (int k = 0; k < row.ninj; k++)
            flip_at[ALIGN_WORDS + 3 * k + 1 + int'(lcg_next() % 2)] = 1'b1;
        @(posedge clk_adc);
        src_i       <= row.src;
        thresh_i    <= row.thresh;
        gen_eqn_i   <= row.eqn;
        chk_eqn_i   <= row.eqn;
        gen_seed_i  <= row.seed;
        lane_mask_i <= row.mask;
        model_state = row.seed;
        apply_reset();
        last = ALIGN_WORDS + row.nwords;
        for (int t = 0; t < last + 3; t++) begin
            @(posedge clk_adc);
            mode_i <= (t >= ALIGN_WORDS + 2 && t < last + 2) ? CHK_TEST : CHK_ALIGN;
            gen_cke_i     <= (row.src == SRC_BIST) && (t < last);
            gen_inj_err_i <= (row.src == SRC_BIST) && (t < last) && flip_at[t + 1];
            if (row.src == SRC_ADC && t < last) begin
                for (int i = 0; i < `NTI; i++) begin
                    b = model_next(row.eqn);
                    cv[i] = code_for(b ^ (i == 0 && flip_at[t]), row.thresh);
                end
                codes_i <= cv;
            end
        end
        read_half(ERR_LO, row.exp_err);
        read_half(ERR_HI, 32'd0);
        read_half(TOT_LO, row.exp_tot);
        read_half(TOT_HI, 32'd0);
        // clear, then every half must read zero
        @(posedge clk_adc);
        mode_i <= CHK_CLEAR;
        read_half(ERR_LO, 32'd0);
        read_half(ERR_HI, 32'd0);
        read_half(TOT_LO, 32'd0);
        read_half(TOT_HI, 32'd0);
    endtask

    initial begin
        int limit_cycles;
        rst_i = 1'b1;
        codes_i = '0;
        thresh_i = '0;
        src_i = SRC_ADC;
        gen_cke_i = 1'b0;
        gen_seed_i = 32'h7f;
        gen_eqn_i = 32'h60;
        gen_inj_err_i = 1'b0;
        dump_start_i = 1'b0;
        rd_addr_i = '0;
        mode_i = CHK_CLEAR;
        chk_eqn_i = 32'h60;
        lane_mask_i = '1;
        rd_sel_i = ERR_LO;
        // PRBS7, taps 7 and 6; one injected bit costs 3 errors
        rows[0] = '{SRC_BIST, 8'd0,   32'h60, 32'h7f, 16'hffff, 20, 0, 0,  320};
        rows[1] = '{SRC_BIST, 8'd0,   32'h60, 32'h55, 16'hffff, 24, 4, 12, 384};
        // lanes 0, 6 and 7 masked, so injected errors vanish
        rows[2] = '{SRC_BIST, 8'd0,   32'h60, 32'h3c, 16'hff3e, 16, 3, 0,  208};
        rows[3] = '{SRC_ADC,  8'd10,  32'h60, 32'h4b, 16'hffff, 30, 5, 15, 480};
        rows[4] = '{SRC_ADC,  8'hec,  32'h60, 32'h19, 16'hffff, 10, 0, 0,  160};
        limit_cycles = 200 + 3 * `CAP_DEPTH + 20;
        foreach (rows[r])
            limit_cycles += rows[r].nwords + 40;
        fork
            begin
                #(limit_cycles * 40);
                $display("watchdog expired after %0d cycles, run did not finish", limit_cycles);
                $display("CHECKS FAILED");
                $finish;
            end
        join_none
        capture_window();
        foreach (rows[r])
            run_row(rows[r]);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/prbs_bist_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "prbs_defs.svh"

module prbs_bist_assert import prbs_pkg::*; (
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    // retiming stage
    input  wire logic             valid_in_i,
    input  wire logic             valid_out_i,
    // capture window
    input  wire logic             start_i,
    input  wire logic             done_i,
    // checker counters
    input  wire chk_mode_e        mode_i,
    input  wire logic [`CNT_W-1:0] err_cnt_i,
    input  wire logic [`CNT_W-1:0] tot_cnt_i
);

    // retimed valid is the stage 1 valid one cycle later
    valid_delay_a: assert property (@(posedge clk_i) disable iff (rst_i)
        !$past(rst_i) |-> valid_out_i == $past(valid_in_i))
        else $error("chk_valid does not follow rx_valid by one cycle");

    // a finished window stays finished until re-armed
    done_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
        (done_i && !start_i) |=> done_i)
        else $error("cap_done dropped without dump_start");

    counts_grow_a: assert property (@(posedge clk_i) disable iff (rst_i)
        (mode_i != CHK_CLEAR) |=>
            (err_cnt_i >= $past(err_cnt_i)) && (tot_cnt_i >= $past(tot_cnt_i)))
        else $error("counter decreased outside CHK_CLEAR");

endmodule

`default_nettype wire

// File: design/prbs_bist_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "prbs_defs.svh"

module prbs_bist_top import prbs_pkg::*; (
    input  wire logic                        clk_adc,
    input  wire logic                        rst_i,
    // receive path
    input  wire logic [`NTI-1:0][`NADC-1:0]  codes_i,
    input  wire logic [`NADC-1:0]            thresh_i,
    input  wire rx_src_e                     src_i,
    // BIST generator
    input  wire logic                        gen_cke_i,
    input  wire logic [`NPRBS-1:0]           gen_seed_i,
    input  wire logic [`NPRBS-1:0]           gen_eqn_i,
    input  wire logic                        gen_inj_err_i,
    // capture window
    input  wire logic                        dump_start_i,
    input  wire logic [`CAP_AW-1:0]          rd_addr_i,
    output logic      [`NTI-1:0]             rd_word_o,
    output logic                             cap_done_o,
    // checker
    input  wire chk_mode_e                   mode_i,
    input  wire logic [`NPRBS-1:0]           chk_eqn_i,
    input  wire logic [`NTI-1:0]             lane_mask_i,
    input  wire rd_sel_e                     rd_sel_i,
    output logic      [`RD_W-1:0]            rd_data_o
);

    logic [`NTI-1:0] rx_bits;
    logic            rx_valid;
    logic [`NTI-1:0] chk_bits;
    logic            chk_valid;

    rx_bit_source rx_bit_source_i (
        .clk_adc       (clk_adc),
        .rst_i         (rst_i),
        .codes_i       (codes_i),
        .thresh_i      (thresh_i),
        .src_i         (src_i),
        .gen_cke_i     (gen_cke_i),
        .gen_seed_i    (gen_seed_i),
        .gen_eqn_i     (gen_eqn_i),
        .gen_inj_err_i (gen_inj_err_i),
        .rx_bits_o     (rx_bits),
        .rx_valid_o    (rx_valid)
    );

    capture_memory capture_memory_i (
        .clk_adc      (clk_adc),
        .rst_i        (rst_i),
        .rx_bits_i    (rx_bits),
        .rx_valid_i   (rx_valid),
        .dump_start_i (dump_start_i),
        .rd_addr_i    (rd_addr_i),
        .rd_word_o    (rd_word_o),
        .cap_done_o   (cap_done_o),
        .chk_bits_o   (chk_bits),
        .chk_valid_o  (chk_valid)
    );

    prbs_checker prbs_checker_i (
        .clk_adc     (clk_adc),
        .rst_i       (rst_i),
        .chk_bits_i  (chk_bits),
        .chk_valid_i (chk_valid),
        .mode_i      (mode_i),
        .eqn_i       (chk_eqn_i),
        .lane_mask_i (lane_mask_i),
        .rd_sel_i    (rd_sel_i),
        .rd_data_o   (rd_data_o)
    );

endmodule

`default_nettype wire

// File: design/prbs_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "prbs_defs.svh"

module prbs_checker import prbs_pkg::*; (
    input  wire logic              clk_adc,
    input  wire logic              rst_i,
    input  wire logic [`NTI-1:0]   chk_bits_i,
    input  wire logic              chk_valid_i,
    input  wire chk_mode_e         mode_i,
    input  wire logic [`NPRBS-1:0] eqn_i,
    // lanes taking part in the count
    input  wire logic [`NTI-1:0]   lane_mask_i,
    input  wire rd_sel_e           rd_sel_i,
    output logic      [`RD_W-1:0]  rd_data_o
);

    localparam int SUM_W = $clog2(`NTI + 1);

    // hist[0] holds the latest received bit
    logic [`NPRBS-1:0] hist;
    logic [`NPRBS-1:0] hist_next;
    logic [`NTI-1:0]   pred;
    logic [`NTI-1:0]   lane_err;
    logic [SUM_W-1:0]  n_err;
    logic [SUM_W-1:0]  n_lanes;
    count_u            err_cnt;
    count_u            tot_cnt;

    // predict each lane from received bits only, so the checker
    // locks onto any phase of the sequence
    always_comb begin
        hist_next = hist;
        for (int i = 0; i < `NTI; i++) begin
            pred[i]     = ^(hist_next & eqn_i);
            lane_err[i] = (pred[i] ^ chk_bits_i[i]) & lane_mask_i[i];
            hist_next   = {hist_next[`NPRBS-2:0], chk_bits_i[i]};
        end
    end

    // mismatches and enabled lanes in this word
    always_comb begin
        n_err   = '0;
        n_lanes = '0;
        for (int i = 0; i < `NTI; i++) begin
            n_err   = n_err + SUM_W'(lane_err[i]);
            n_lanes = n_lanes + SUM_W'(lane_mask_i[i]);
        end
    end

    // history follows the stream while aligning or testing
    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            hist <= '0;
        end else if (chk_valid_i && (mode_i == CHK_ALIGN || mode_i == CHK_TEST)) begin
            hist <= hist_next;
        end
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            err_cnt.full <= '0;
            tot_cnt.full <= '0;
        end else if (mode_i == CHK_CLEAR) begin
            err_cnt.full <= '0;
            tot_cnt.full <= '0;
        end else if (chk_valid_i && mode_i == CHK_TEST) begin
            err_cnt.full <= err_cnt.full + `CNT_W'(n_err);
            tot_cnt.full <= tot_cnt.full + `CNT_W'(n_lanes);
        end
    end

    // readout mux
    always_comb begin
        case (rd_sel_i)
            ERR_LO:  rd_data_o = err_cnt.half.lo;
            ERR_HI:  rd_data_o = err_cnt.half.hi;
            TOT_LO:  rd_data_o = tot_cnt.half.lo;
            TOT_HI:  rd_data_o = tot_cnt.half.hi;
            default: rd_data_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/capture_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "prbs_defs.svh"

module capture_memory (
    input  wire logic              clk_adc,
    input  wire logic              rst_i,
    input  wire logic [`NTI-1:0]   rx_bits_i,
    input  wire logic              rx_valid_i,
    input  wire logic              dump_start_i,
    input  wire logic [`CAP_AW-1:0] rd_addr_i,
    output logic      [`NTI-1:0]   rd_word_o,
    output logic                   cap_done_o,
    output logic      [`NTI-1:0]   chk_bits_o,
    output logic                   chk_valid_o
);

    logic [`NTI-1:0]    mem [`CAP_DEPTH];
    logic [`CAP_AW-1:0] wr_ptr;
    logic               armed;
    logic               wr_en;
    logic               last_word;

    // retiming stage toward the checker
    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            chk_valid_o <= 1'b0;
        end else begin
            chk_valid_o <= rx_valid_i;
        end
    end

    always_ff @(posedge clk_adc) begin
        chk_bits_o <= rx_bits_i;
    end

    // the start pulse itself does not write
    assign wr_en     = armed && rx_valid_i && !dump_start_i;
    assign last_word = (wr_ptr == `CAP_AW'(`CAP_DEPTH - 1));

    // one-shot window control
    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            armed      <= 1'b0;
            wr_ptr     <= '0;
            cap_done_o <= 1'b0;
        end else if (dump_start_i) begin
            armed      <= 1'b1;
            wr_ptr     <= '0;
            cap_done_o <= 1'b0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
            if (last_word) begin
                armed      <= 1'b0;
                cap_done_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        if (wr_en) begin
            mem[wr_ptr] <= rx_bits_i;
        end
    end

    // registered read port
    always_ff @(posedge clk_adc) begin
        rd_word_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

// File: design/rx_bit_source.sv
`timescale 1ns/1ps
`default_nettype none

`include "prbs_defs.svh"

module rx_bit_source import prbs_pkg::*; (
    input  wire logic                        clk_adc,
    input  wire logic                        rst_i,
    // interleaved ADC codes, lane 0 earliest
    input  wire logic [`NTI-1:0][`NADC-1:0]  codes_i,
    input  wire logic [`NADC-1:0]            thresh_i,
    input  wire rx_src_e                     src_i,
    // BIST generator controls
    input  wire logic                        gen_cke_i,
    input  wire logic [`NPRBS-1:0]           gen_seed_i,
    input  wire logic [`NPRBS-1:0]           gen_eqn_i,
    input  wire logic                        gen_inj_err_i,
    output logic      [`NTI-1:0]             rx_bits_o,
    output logic                             rx_valid_o
);

    logic [`NTI-1:0] adc_bits;
    logic [`NTI-1:0] gen_bits;
    logic [`NTI-1:0] sel_bits;
    logic            sel_valid;

    prbs_generator prbs_generator_i (
        .clk_adc   (clk_adc),
        .rst_i     (rst_i),
        .cke_i     (gen_cke_i),
        .seed_i    (gen_seed_i),
        .eqn_i     (gen_eqn_i),
        .inj_err_i (gen_inj_err_i),
        .bits_o    (gen_bits)
    );

    // slicer, signed compare per lane
    always_comb begin
        for (int i = 0; i < `NTI; i++) begin
            adc_bits[i] = $signed(codes_i[i]) > $signed(thresh_i);
        end
    end

    // ADC codes arrive every cycle, the generator only when enabled
    always_comb begin
        if (src_i == SRC_BIST) begin
            sel_bits  = gen_bits;
            sel_valid = gen_cke_i;
        end else begin
            sel_bits  = adc_bits;
            sel_valid = 1'b1;
        end
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= sel_valid;
        end
    end

    always_ff @(posedge clk_adc) begin
        rx_bits_o <= sel_bits;
    end

endmodule

`default_nettype wire

// File: design/prbs_generator.sv
`timescale 1ns/1ps
`default_nettype none

`include "prbs_defs.svh"

module prbs_generator (
    input  wire logic              clk_adc,
    input  wire logic              rst_i,
    input  wire logic              cke_i,
    input  wire logic [`NPRBS-1:0] seed_i,
    input  wire logic [`NPRBS-1:0] eqn_i,
    input  wire logic              inj_err_i,
    output logic      [`NTI-1:0]   bits_o
);

    // state[0] is the most recent bit
    logic [`NPRBS-1:0] state;
    logic [`NPRBS-1:0] state_next;
    logic [`NTI-1:0]   word;
    logic              inj_pend;

    // unroll sixteen steps of the recurrence, lane 0 first
    always_comb begin
        state_next = state;
        for (int i = 0; i < `NTI; i++) begin
            word[i]    = ^(state_next & eqn_i);
            state_next = {state_next[`NPRBS-2:0], word[i]};
        end
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            state <= seed_i;
        end else if (cke_i) begin
            state <= state_next;
        end
    end

    // injected error waits for the next word that goes out
    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            inj_pend <= 1'b0;
        end else if (cke_i) begin
            inj_pend <= inj_err_i;
        end else if (inj_err_i) begin
            inj_pend <= 1'b1;
        end
    end

    // flip only the output, history stays clean
    assign bits_o = {word[`NTI-1:1], word[0] ^ inj_pend};

endmodule

`default_nettype wire

// File: design/prbs_pkg.sv
`default_nettype none

`include "prbs_defs.svh"

package prbs_pkg;

    // which stream feeds the checker
    typedef enum logic {
        SRC_ADC  = 1'b0,
        SRC_BIST = 1'b1
    } rx_src_e;

    typedef enum logic [1:0] {
        CHK_CLEAR = 2'd0,
        CHK_ALIGN = 2'd1,
        CHK_TEST  = 2'd2
    } chk_mode_e;

    // counter half presented on the readout port
    typedef enum logic [1:0] {
        ERR_LO = 2'd0,
        ERR_HI = 2'd1,
        TOT_LO = 2'd2,
        TOT_HI = 2'd3
    } rd_sel_e;

    typedef struct packed {
        logic [`RD_W-1:0] hi;
        logic [`RD_W-1:0] lo;
    } count_halves_t;

    // a counter seen either whole or as two readout words
    typedef union packed {
        logic [`CNT_W-1:0] full;
        count_halves_t     half;
    } count_u;

endpackage

`default_nettype wire

// File: design/prbs_defs.svh
`ifndef PRBS_DEFS_SVH
`define PRBS_DEFS_SVH

// interleaved lanes per word
`define NTI 16

// signed ADC code width
`define NADC 8

// history and tap register width
`define NPRBS 32

// capture window size and address width
`define CAP_DEPTH 64
`define CAP_AW 6

// error and total counters
`define CNT_W 64

// readout word, one half of a counter
`define RD_W 32

`endif
